//--- common/uart_pkg.sv
// Fixed 8N1 or 8-bit-plus-parity framing only, FIFO depth and reset divisor are not configurable
package uart_pkg;

  // ----------------------------------------------------------
  // Plain vector types
  // ----------------------------------------------------------
  // Serial data byte
  typedef logic [7:0]  uart_byte_t;
  // Baud divisor, DLM:DLL
  typedef logic [15:0] divisor_t;
  // APB register offset
  typedef logic [2:0]  reg_addr_t;
  // FIFO fill level, 0 to FIFO_DEPTH
  typedef logic [4:0]  fifo_cnt_t;

  // ----------------------------------------------------------
  // Sizes and register map
  // ----------------------------------------------------------
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // Divisor after reset
  localparam divisor_t DL_RESET = 16'd1;

  // DLL and DLM share offsets 0 and 1 while DLAB is set
  localparam reg_addr_t ADDR_RBR_THR = 3'd0;
  localparam reg_addr_t ADDR_IER     = 3'd1;
  localparam reg_addr_t ADDR_IIR_FCR = 3'd2;
  localparam reg_addr_t ADDR_LCR     = 3'd3;
  localparam reg_addr_t ADDR_LSR     = 3'd5;
  localparam reg_addr_t ADDR_SCR     = 3'd7;

  // ----------------------------------------------------------
  // Structs
  // ----------------------------------------------------------
  // Receive FIFO entry, error bits on top
  typedef struct packed {
    logic       fe;
    logic       pe;
    uart_byte_t data;
  } rx_word_t;

  // Line setup shared by transmitter and receiver
  typedef struct packed {
    logic     pen;
    logic     eps;
    divisor_t dl;
  } line_cfg_t;

  // APB request, narrowed to the UART register space
  typedef struct packed {
    logic       psel;
    logic       penable;
    logic       pwrite;
    reg_addr_t  paddr;
    uart_byte_t pwdata;
  } apb_req_t;

  // Serial state machines
  typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_t;
  typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_t;

endpackage

//--- source/uart16550_fifo.sv
// Pushes while full and pops while empty are ignored, flush wins over both
`timescale 1ns/1ps

module uart16550_fifo #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  flush_i,
  input  logic                  push_i,
  input  logic                  pop_i,
  input  logic [DATA_WIDTH-1:0] d_i,
  output logic [DATA_WIDTH-1:0] q_o,
  output logic                  empty_o,
  output logic                  full_o,
  output logic                  overrun_o,
  output logic                  err_o,
  input  uart_pkg::fifo_cnt_t   trigger_lvl_i,
  output logic                  trigger_o
);
  import uart_pkg::*;

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0]    wr_ptr;
  logic [FIFO_AW-1:0]    rd_ptr;
  fifo_cnt_t             count;
  // One flag per slot, set when the stored word has error bits
  logic [FIFO_DEPTH-1:0] err_flag;
  logic                  do_push;
  logic                  do_pop;

  assign empty_o   = (count == '0);
  assign full_o    = (count == fifo_cnt_t'(FIFO_DEPTH));
  assign do_push   = push_i & ~full_o;
  assign do_pop    = pop_i & ~empty_o;
  assign overrun_o = push_i & full_o;
  assign trigger_o = (count >= trigger_lvl_i);
  assign err_o     = |err_flag;

  // Head word read combinationally
  assign q_o = mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      err_flag <= '0;
    end else begin
      if (do_push) begin
        wr_ptr           <= wr_ptr + FIFO_AW'(1);
        err_flag[wr_ptr] <= |d_i[DATA_WIDTH-1 -: 2];
      end
      // Slots differ whenever both act, since neither full nor empty
      if (do_pop) begin
        rd_ptr           <= rd_ptr + FIFO_AW'(1);
        err_flag[rd_ptr] <= 1'b0;
      end
      count <= count + fifo_cnt_t'(do_push) - fifo_cnt_t'(do_pop);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push && !flush_i) mem[wr_ptr] <= d_i;
  end

endmodule

//--- uart16550_tx/uart16550_tx.sv
// Always 8 data bits and 1 stop bit, frames start on a baud tick
`timescale 1ns/1ps

module uart16550_tx (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  baud_tick_i,
  input  uart_pkg::line_cfg_t   cfg_i,
  input  logic                  empty_i,
  input  uart_pkg::uart_byte_t  d_i,
  output logic                  pop_o,
  output logic                  idle_o,
  output logic                  sout_o
);
  import uart_pkg::*;

  tx_state_t  state;
  // 16 ticks per bit
  logic [3:0] tick_cnt;
  logic [2:0] bit_cnt;
  uart_byte_t data_q;
  logic       par_q;

  assign idle_o = (state == TX_IDLE);
  // Take the head word on a tick so the start bit is a full 16 ticks
  assign pop_o  = idle_o & ~empty_i & baud_tick_i;

  // Load frame payload, parity fixed at load time
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      data_q <= d_i;
      // EPS set gives even parity
      par_q  <= (^d_i) ^ ~cfg_i.eps;
    end
  end

  // ----------------------------------------------------------
  // Bit sequencer
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state    <= TX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      sout_o   <= 1'b1;
    end else if (pop_o) begin
      // Start bit goes out now
      state    <= TX_START;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      sout_o   <= 1'b0;
    end else if (baud_tick_i && !idle_o) begin
      if (tick_cnt != 4'd15) begin
        tick_cnt <= tick_cnt + 4'd1;
      end else begin
        // End of current bit
        tick_cnt <= '0;
        case (state)
          TX_START: begin
            state  <= TX_DATA;
            sout_o <= data_q[0];
          end
          TX_DATA: begin
            if (bit_cnt != 3'd7) begin
              // LSB first
              bit_cnt <= bit_cnt + 3'd1;
              sout_o  <= data_q[bit_cnt + 3'd1];
            end else if (cfg_i.pen) begin
              state  <= TX_PARITY;
              sout_o <= par_q;
            end else begin
              state  <= TX_STOP;
              sout_o <= 1'b1;
            end
          end
          TX_PARITY: begin
            state  <= TX_STOP;
            sout_o <= 1'b1;
          end
          default: state <= TX_IDLE;
        endcase
      end
    end
  end

endmodule

//--- uart16550_rx/uart16550_rx.sv
// sin_i may be asynchronous, frames must be 8 data bits and 1 stop bit, break not detected
`timescale 1ns/1ps

module uart16550_rx (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  baud_tick_i,
  input  uart_pkg::line_cfg_t   cfg_i,
  input  logic                  sin_i,
  output logic                  push_o,
  output uart_pkg::rx_word_t    q_o
);
  import uart_pkg::*;

  rx_state_t  state;
  // Two-flop synchronizer plus edge history
  logic       sin_meta;
  logic       sin_sync;
  logic       sin_prev;
  logic       fall;
  logic [3:0] tick_cnt;
  logic [2:0] bit_cnt;
  logic       sample;
  uart_byte_t data_q;
  logic       pe_q;
  logic       fe_q;

  assign fall = sin_prev & ~sin_sync;

  // Start bit checked at tick 8, later bits every 16 ticks after that
  assign sample = baud_tick_i &&
                  ((state == RX_START) ? (tick_cnt == 4'd7) : (tick_cnt == 4'd15));

  assign q_o = '{fe: fe_q, pe: pe_q, data: data_q};

  // Data bits, LSB first
  always_ff @(posedge clk_i) begin
    if (sample && state == RX_DATA) data_q[bit_cnt] <= sin_sync;
  end

  // ----------------------------------------------------------
  // Frame FSM
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sin_meta <= 1'b1;
      sin_sync <= 1'b1;
      sin_prev <= 1'b1;
      state    <= RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      push_o   <= 1'b0;
      pe_q     <= 1'b0;
      fe_q     <= 1'b0;
    end else begin
      sin_meta <= sin_i;
      sin_sync <= sin_meta;
      sin_prev <= sin_sync;
      push_o   <= 1'b0;
      if (state == RX_IDLE) begin
        if (fall) begin
          state    <= RX_START;
          tick_cnt <= '0;
        end
      end else if (sample) begin
        tick_cnt <= '0;
        case (state)
          RX_START: begin
            // High again at mid-bit means a glitch
            if (!sin_sync) begin
              state   <= RX_DATA;
              bit_cnt <= '0;
              pe_q    <= 1'b0;
            end else begin
              state <= RX_IDLE;
            end
          end
          RX_DATA: begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= cfg_i.pen ? RX_PARITY : RX_STOP;
          end
          RX_PARITY: begin
            // Expected bit is even parity when EPS is set
            pe_q  <= sin_sync != ((^data_q) ^ ~cfg_i.eps);
            state <= RX_STOP;
          end
          default: begin
            // Mid stop bit, hand the word over
            fe_q   <= ~sin_sync;
            push_o <= 1'b1;
            state  <= RX_IDLE;
          end
        endcase
      end else if (baud_tick_i) begin
        tick_cnt <= tick_cnt + 4'd1;
      end
    end
  end

endmodule

//--- source/uart16550_regs.sv
// WLS/STB read fixed as 8 bits and 1 stop, MCR/MSR read zero, divisor 0 halts the baud tick
`timescale 1ns/1ps

module uart16550_regs (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  re_i,
  input  logic                  we_i,
  input  uart_pkg::reg_addr_t   adr_i,
  input  uart_pkg::uart_byte_t  d_i,
  output uart_pkg::uart_byte_t  q_o,
  output uart_pkg::line_cfg_t   cfg_o,
  output logic                  baud_tick_o,
  output logic                  tx_push_o,
  output logic                  tx_flush_o,
  input  logic                  tx_empty_i,
  input  logic                  tx_idle_i,
  output logic                  rx_pop_o,
  output logic                  rx_flush_o,
  input  uart_pkg::rx_word_t    rx_q_i,
  input  logic                  rx_empty_i,
  input  logic                  rx_err_i,
  input  logic                  rx_overrun_i,
  output uart_pkg::fifo_cnt_t   rx_trigger_lvl_o,
  input  logic                  rx_trigger_i,
  output logic                  irq_o
);
  import uart_pkg::*;

  // IER: ELSI, ETBEI, ERBFI
  logic [2:0] ier_q;
  // LCR bits kept
  logic       dlab_q;
  logic       eps_q;
  logic       pen_q;
  uart_byte_t scr_q;
  divisor_t   dl_q;
  divisor_t   baud_cnt;
  logic       oe_q;
  fifo_cnt_t  trig_lvl_q;

  uart_byte_t lsr;
  logic [3:0] iid;
  logic       line_err;

  // ----------------------------------------------------------
  // Access decode
  // ----------------------------------------------------------
  // THR and RBR only while DLAB is clear
  assign tx_push_o  = we_i & (adr_i == ADDR_RBR_THR) & ~dlab_q;
  assign rx_pop_o   = re_i & (adr_i == ADDR_RBR_THR) & ~dlab_q;

  // FCR bit 1 flushes RX, bit 2 flushes TX
  assign rx_flush_o = we_i & (adr_i == ADDR_IIR_FCR) & d_i[1];
  assign tx_flush_o = we_i & (adr_i == ADDR_IIR_FCR) & d_i[2];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ier_q      <= '0;
      dlab_q     <= 1'b0;
      eps_q      <= 1'b0;
      pen_q      <= 1'b0;
      scr_q      <= '0;
      dl_q       <= DL_RESET;
      trig_lvl_q <= fifo_cnt_t'(1);
    end else if (we_i) begin
      case (adr_i)
        ADDR_RBR_THR: if (dlab_q) dl_q[7:0] <= d_i;
        ADDR_IER: begin
          if (dlab_q) begin
            dl_q[15:8] <= d_i;
          end else begin
            ier_q <= d_i[2:0];
          end
        end
        ADDR_IIR_FCR: begin
          // RX trigger select
          case (d_i[7:6])
            2'b00:   trig_lvl_q <= fifo_cnt_t'(1);
            2'b01:   trig_lvl_q <= fifo_cnt_t'(4);
            2'b10:   trig_lvl_q <= fifo_cnt_t'(8);
            default: trig_lvl_q <= fifo_cnt_t'(14);
          endcase
        end
        ADDR_LCR: begin
          dlab_q <= d_i[7];
          eps_q  <= d_i[4];
          pen_q  <= d_i[3];
        end
        ADDR_SCR: scr_q <= d_i;
        default: ;
      endcase
    end
  end

  assign rx_trigger_lvl_o = trig_lvl_q;
  assign cfg_o            = '{pen: pen_q, eps: eps_q, dl: dl_q};

  // ----------------------------------------------------------
  // Baud tick, one pulse every DL clocks
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      baud_cnt    <= '0;
      baud_tick_o <= 1'b0;
    end else if (dl_q == '0) begin
      // Stopped
      baud_cnt    <= '0;
      baud_tick_o <= 1'b0;
    end else if (baud_cnt >= dl_q - 16'd1) begin
      baud_cnt    <= '0;
      baud_tick_o <= 1'b1;
    end else begin
      baud_cnt    <= baud_cnt + 16'd1;
      baud_tick_o <= 1'b0;
    end
  end

  // ----------------------------------------------------------
  // Line status
  // ----------------------------------------------------------
  // Overrun is sticky until LSR is read, a new overrun wins
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      oe_q <= 1'b0;
    end else if (rx_overrun_i) begin
      oe_q <= 1'b1;
    end else if (re_i && adr_i == ADDR_LSR) begin
      oe_q <= 1'b0;
    end
  end

  // PE/FE belong to the word at the head of the RX FIFO
  assign lsr = {rx_err_i,
                tx_empty_i & tx_idle_i,
                tx_empty_i,
                1'b0,
                rx_q_i.fe & ~rx_empty_i,
                rx_q_i.pe & ~rx_empty_i,
                oe_q,
                ~rx_empty_i};

  // OE, PE, FE (BI always zero)
  assign line_err = |lsr[4:1];

  // ----------------------------------------------------------
  // Interrupt identification, highest priority first
  // ----------------------------------------------------------
  always_comb begin
    if (ier_q[2] && line_err) begin
      iid = 4'h6;
    end else if (ier_q[0] && rx_trigger_i) begin
      iid = 4'h4;
    end else if (ier_q[1] && tx_empty_i) begin
      iid = 4'h2;
    end else begin
      iid = 4'h1;
    end
  end

  // Bit 0 of IIR is active low pending
  assign irq_o = ~iid[0];

  // Read mux
  always_comb begin
    case (adr_i)
      ADDR_RBR_THR: q_o = dlab_q ? dl_q[7:0] : rx_q_i.data;
      ADDR_IER:     q_o = dlab_q ? dl_q[15:8] : {5'b0, ier_q};
      ADDR_IIR_FCR: q_o = {4'b1100, iid};
      // WLS=3, STB=0, no break or stick parity
      ADDR_LCR:     q_o = {dlab_q, 2'b00, eps_q, pen_q, 3'b011};
      ADDR_LSR:     q_o = lsr;
      ADDR_SCR:     q_o = scr_q;
      default:      q_o = '0;
    endcase
  end

endmodule

//--- source/apb_uart16550.sv
// Zero-wait APB slave without pready/pslverr, no modem lines, FIFOs always enabled
`timescale 1ns/1ps

module apb_uart16550 (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  uart_pkg::apb_req_t    apb_req_i,
  output uart_pkg::uart_byte_t  prdata_o,
  input  logic                  sin_i,
  output logic                  sout_o,
  output logic                  intr_o
);
  import uart_pkg::*;

  // APB strobes
  logic       apb_rd;
  logic       apb_wr;

  // Shared line setup and timing
  line_cfg_t  cfg;
  logic       baud_tick;

  // Transmit path
  logic       tx_push;
  logic       tx_pop;
  logic       tx_flush;
  logic       tx_empty;
  logic       tx_idle;
  uart_byte_t tx_q;

  // Receive path
  logic       rx_push;
  logic       rx_pop;
  logic       rx_flush;
  logic       rx_empty;
  logic       rx_err;
  logic       rx_overrun;
  logic       rx_trigger;
  fifo_cnt_t  rx_trigger_lvl;
  rx_word_t   rx_d;
  rx_word_t   rx_q;

  // ----------------------------------------------------------
  // APB decode, every access completes in its access cycle
  // ----------------------------------------------------------
  assign apb_rd = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;
  assign apb_wr = apb_req_i.psel & apb_req_i.penable &  apb_req_i.pwrite;

  uart16550_regs regs (
    .clk_i, .rst_n_i,
    .re_i (apb_rd), .we_i (apb_wr),
    .adr_i (apb_req_i.paddr), .d_i (apb_req_i.pwdata), .q_o (prdata_o),
    .cfg_o (cfg), .baud_tick_o (baud_tick),
    .tx_push_o (tx_push), .tx_flush_o (tx_flush),
    .tx_empty_i (tx_empty), .tx_idle_i (tx_idle),
    .rx_pop_o (rx_pop), .rx_flush_o (rx_flush), .rx_q_i (rx_q),
    .rx_empty_i (rx_empty), .rx_err_i (rx_err), .rx_overrun_i (rx_overrun),
    .rx_trigger_lvl_o (rx_trigger_lvl), .rx_trigger_i (rx_trigger),
    .irq_o (intr_o)
  );

  // THR data comes straight from pwdata
  uart16550_fifo #(.DATA_WIDTH (8)) tx_fifo (
    .clk_i, .rst_n_i,
    .flush_i (tx_flush), .push_i (tx_push), .pop_i (tx_pop),
    .d_i (apb_req_i.pwdata), .q_o (tx_q),
    .empty_o (tx_empty), .full_o (), .overrun_o (), .err_o (),
    .trigger_lvl_i (fifo_cnt_t'(FIFO_DEPTH)), .trigger_o ()
  );

  uart16550_tx tx (
    .clk_i, .rst_n_i,
    .baud_tick_i (baud_tick), .cfg_i (cfg),
    .empty_i (tx_empty), .d_i (tx_q), .pop_o (tx_pop),
    .idle_o (tx_idle), .sout_o
  );

  uart16550_rx rx (
    .clk_i, .rst_n_i,
    .baud_tick_i (baud_tick), .cfg_i (cfg),
    .sin_i, .push_o (rx_push), .q_o (rx_d)
  );

  // Entry carries data plus PE/FE flags
  uart16550_fifo #(.DATA_WIDTH ($bits(rx_word_t))) rx_fifo (
    .clk_i, .rst_n_i,
    .flush_i (rx_flush), .push_i (rx_push), .pop_i (rx_pop),
    .d_i (rx_d), .q_o (rx_q),
    .empty_o (rx_empty), .full_o (), .overrun_o (rx_overrun), .err_o (rx_err),
    .trigger_lvl_i (rx_trigger_lvl), .trigger_o (rx_trigger)
  );

endmodule

//--- dv/uart_checker.sv
// Compares only while the testbench arms a check, read data is taken in the APB access cycle
`timescale 1ns/1ps

module uart_checker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  uart_pkg::apb_req_t    apb_req_i,
  input  uart_pkg::uart_byte_t  prdata_i,
  input  logic                  intr_i,
  input  logic                  rd_chk_i,
  input  uart_pkg::uart_byte_t  rd_mask_i,
  input  uart_pkg::uart_byte_t  rd_exp_i,
  input  logic                  intr_chk_i,
  input  logic                  intr_exp_i,
  output uart_pkg::uart_byte_t  rd_data_o,
  output int                    err_cnt_o
);
  import uart_pkg::*;

  logic rd_strobe;
  int   mismatches = 0;

  // ----------------------------------------------------------
  // APB read strobe, as the slave sees it
  // ----------------------------------------------------------
  assign rd_strobe = apb_req_i.psel & apb_req_i.penable & ~apb_req_i.pwrite;
  assign err_cnt_o = mismatches;

  // Values before the edge that ends the access
  always @(posedge clk_i) begin
    if (rst_n_i && rd_strobe) begin
      // Last read value, for polling loops
      rd_data_o <= prdata_i;
      if (rd_chk_i && ((prdata_i & rd_mask_i) !== (rd_exp_i & rd_mask_i))) begin
        $display("Mismatch at %0t ns: offset %0d read %02h, mask %02h, expected %02h",
                 $time, apb_req_i.paddr, prdata_i, rd_mask_i, rd_exp_i);
        mismatches = mismatches + 1;
      end
    end
    // Interrupt level
    if (rst_n_i && intr_chk_i && (intr_i !== intr_exp_i)) begin
      $display("Mismatch at %0t ns: intr_o is %b, expected %b",
               $time, intr_i, intr_exp_i);
      mismatches = mismatches + 1;
    end
  end

endmodule

//--- dv/tb_apb_uart16550.sv
// Inject bit timing assumes DL 1 (16 clocks per bit), steps come from dv/uart_tests.txt
`timescale 1ns/1ps

module tb_apb_uart16550;
  import uart_pkg::*;

  localparam int CLK_HALF   = 10;
  localparam int RST_CYCLES = 16;
  localparam int MAX_POLLS  = 2000;
  // 16 baud ticks per bit, one tick per clock at DL 1
  localparam int BIT_CLKS   = 16;

  logic        clk;
  logic        rst_n;
  apb_req_t    apb_req;
  uart_byte_t  prdata;
  logic        sin;
  logic        sout;
  logic        intr;

  // Serial line source select
  logic        loopback;
  logic        inj_line;

  // Expectations handed to the checker
  logic        rd_chk;
  uart_byte_t  rd_mask;
  uart_byte_t  rd_exp;
  logic        intr_chk;
  logic        intr_exp;
  uart_byte_t  rd_data;
  int          chk_errors;
  int          tb_errors;

  logic [31:0] tests [0:127];
  uart_byte_t  exp_q [$];
  logic [15:0] lfsr;

  assign sin = loopback ? sout : inj_line;

  always #CLK_HALF clk = ~clk;

  apb_uart16550 dut0 (
    .clk_i (clk), .rst_n_i (rst_n), .apb_req_i (apb_req), .prdata_o (prdata),
    .sin_i (sin), .sout_o (sout), .intr_o (intr)
  );

  uart_checker chk0 (
    .clk_i (clk), .rst_n_i (rst_n), .apb_req_i (apb_req), .prdata_i (prdata),
    .intr_i (intr), .rd_chk_i (rd_chk), .rd_mask_i (rd_mask), .rd_exp_i (rd_exp),
    .intr_chk_i (intr_chk), .intr_exp_i (intr_exp),
    .rd_data_o (rd_data), .err_cnt_o (chk_errors)
  );

  // ----------------------------------------------------------
  // Random bytes
  // ----------------------------------------------------------
  // 16-bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic next_random_byte(output uart_byte_t b);
    int i;
    b = '0;
    for (i = 0; i < 8; i++) begin
      lfsr = lfsr_next(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // ----------------------------------------------------------
  // APB and serial drivers
  // ----------------------------------------------------------
  // Setup cycle, access cycle, then idle; read data valid after return
  task automatic apb_access(input reg_addr_t addr, input logic wr, input uart_byte_t data);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(negedge clk);
    apb_req.penable = 1'b1;
    @(negedge clk);
    apb_req = '0;
  endtask

  task automatic read_check(input reg_addr_t addr, input uart_byte_t mask,
                            input uart_byte_t exp);
    rd_chk  = 1'b1;
    rd_mask = mask;
    rd_exp  = exp;
    apb_access(addr, 1'b0, '0);
    rd_chk  = 1'b0;
  endtask

  // Poll a register until any masked bit is set
  task automatic wait_reg(input reg_addr_t addr, input uart_byte_t mask);
    int   polls;
    logic seen;
    seen = 1'b0;
    for (polls = 0; polls < MAX_POLLS && !seen; polls++) begin
      apb_access(addr, 1'b0, '0);
      seen = |(rd_data & mask);
    end
    if (!seen) begin
      $display("Timeout: offset %0d never showed bits %02h in %0d polls", addr, mask, MAX_POLLS);
      tb_errors++;
    end
  endtask

  task automatic check_intr(input logic exp);
    intr_chk = 1'b1;
    intr_exp = exp;
    @(negedge clk);
    intr_chk = 1'b0;
  endtask

  task automatic send_bit(input logic b);
    @(negedge clk);
    inj_line = b;
    repeat (BIT_CLKS - 1) @(negedge clk);
  endtask

  // mode bit0 parity on, bit1 even; flags bit0 bad parity, bit1 low stop
  task automatic inject_frame(input uart_byte_t data, input logic [1:0] mode,
                              input logic [1:0] flags);
    uart_byte_t d;
    logic       par;
    d   = data;
    // Even parity bit makes the ones count even
    par = mode[1] ? ^data : ~^data;
    if (flags[0]) par = ~par;
    send_bit(1'b0);
    repeat (8) begin
      send_bit(d[0]);
      d = d >> 1;
    end
    if (mode[0]) send_bit(par);
    send_bit(~flags[1]);
    send_bit(1'b1);
  endtask

  // ----------------------------------------------------------
  // Step sequencer
  // ----------------------------------------------------------
  initial begin
    int          step;
    logic        done;
    logic [31:0] t;
    uart_byte_t  op;
    uart_byte_t  adr;
    uart_byte_t  dat;
    uart_byte_t  exv;
    uart_byte_t  b;
    clk       = 1'b0;
    rst_n     = 1'b0;
    apb_req   = '0;
    loopback  = 1'b0;
    inj_line  = 1'b1;
    rd_chk    = 1'b0;
    rd_mask   = '1;
    rd_exp    = '0;
    intr_chk  = 1'b0;
    intr_exp  = 1'b0;
    tb_errors = 0;
    lfsr      = 16'd78;
    foreach (tests[i]) tests[i] = '0;
    $readmemh("dv/uart_tests.txt", tests);
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    done = 1'b0;
    for (step = 0; step < 128 && !done; step++) begin
      t   = tests[step[6:0]];
      op  = t[31:24];
      adr = t[23:16];
      dat = t[15:8];
      exv = t[7:0];
      case (op)
        8'h00: done = 1'b1;
        8'h01: apb_access(adr[2:0], 1'b1, dat);
        8'h02: read_check(adr[2:0], 8'hFF, exv);
        8'h03: wait_reg(adr[2:0], dat);
        8'h04: inject_frame(dat, adr[1:0], exv[1:0]);
        8'h05: check_intr(exv[0]);
        8'h06: begin
          repeat (dat) begin
            next_random_byte(b);
            exp_q.push_back(b);
            apb_access(ADDR_RBR_THR, 1'b1, b);
          end
        end
        8'h07: begin
          // Each byte waits for DR before RBR is read
          repeat (dat) begin
            wait_reg(ADDR_LSR, 8'h01);
            if (exp_q.size() == 0) begin
              $display("RBR read at step %0d with no byte left to expect", step);
              tb_errors++;
            end else begin
              read_check(ADDR_RBR_THR, 8'hFF, exp_q.pop_front());
            end
          end
        end
        8'h08: loopback = dat[0];
        8'h09: read_check(adr[2:0], dat, exv);
        8'h0A: exp_q.delete();
        default: begin
          $display("Unknown opcode %02h at step %0d", op, step);
          tb_errors++;
        end
      endcase
    end

    if (exp_q.size() != 0) begin
      $display("%0d sent bytes were never read back", exp_q.size());
      tb_errors++;
    end
    $display("Errors: %0d mismatches, %0d other failures", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- dv/uart_tests.txt
// One hex word per step: oo opcode, aa offset or inject mode, dd data or mask, ee expected
// 00 end 01 write 02 read 03 poll bits 04 inject 05 intr 06 send rnd 07 recv 08 loop 09 masked 0A drop
// Reset values
02030003
02050060
020200C1
02010000
05000000
// Register access, DLAB window, restore DL 1
0107A500
020700A5
01010500
02010005
01031800
0203001B
01038000
01003400
01011200
02000034
02010012
02030083
01000100
01010000
01030000
02010005
01010000
02030003
// Loopback, no parity, even, odd
08000100
06000300
03050100
09051E00
07000300
01031800
06000200
03050100
09051E00
07000200
01030800
06000200
03050100
09051E00
07000200
03054000
02050060
// Injected parity error, even parity, ELSI on
08000000
01010400
01031800
04035A01
03050100
020500E5
020200C6
05000001
0200005A
02050060
05000000
// Injected framing error, no parity
01030000
0400A302
03050100
020500E9
020200C6
020000A3
02050060
// Overrun after 17 bytes, then receive flush
08000100
06001100
03020400
05000001
09051F03
09051F01
03054000
02050061
07000100
01020200
0A000000
02050060
// Interrupt priority, trigger level 4
01024000
01010300
020200C2
05000001
06000400
03020400
020200C4
07000400
020200C2
01010000
05000000
00000000

//--- apb_uart16550.f
common/uart_pkg.sv
source/uart16550_fifo.sv
uart16550_tx/uart16550_tx.sv
uart16550_rx/uart16550_rx.sv
source/uart16550_regs.sv
source/apb_uart16550.sv
dv/uart_checker.sv
dv/tb_apb_uart16550.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the UART testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f apb_uart16550.f \
  --top-module tb_apb_uart16550 -Mdir obj_dir -o sim_apb_uart16550
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output="$(./obj_dir/sim_apb_uart16550)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1
